/* run.sh */
#!/bin/sh
# build and run the testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module tb_soc_chip_top -o tb_sim

status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi
echo "simulation passed"

/* source/hk_regfile.sv */
`timescale 1ns/1ps

module hk_regfile (
  input  logic              clk_i,
  input  logic              rst_i,
  input  soc_pkg::hk_rx_t   rx_i,
  output logic [7:0]        tx_byte_o,
  output soc_pkg::hk_ctrl_t ctrl_o
);

  import soc_pkg::*;

  logic                 wr_mode_q;
  logic                 rd_mode_q;
  logic                 have_addr_q;
  logic [7:0]           addr_q;
  logic [HK_CTRL_W-1:0] ctrl_q;
  logic [HK_TRIM_W-1:0] trim_q;
  logic [7:0]           rd_data;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_mode_q <= 1'b0;
      rd_mode_q <= 1'b0;
      have_addr_q <= 1'b0;
      addr_q <= '0;
      ctrl_q <= HK_CTRL_RESET[HK_CTRL_W-1:0];
      trim_q <= '0;
    end else if (rx_i.valid) begin
      if (rx_i.first) begin
        // unknown commands leave both modes clear
        wr_mode_q <= (rx_i.data == HK_CMD_WRITE);
        rd_mode_q <= (rx_i.data == HK_CMD_READ);
        have_addr_q <= 1'b0;
      end else if (!have_addr_q) begin
        addr_q <= rx_i.data;
        have_addr_q <= 1'b1;
      end else begin
        addr_q <= addr_q + 8'd1;
        if (wr_mode_q) begin
          case (addr_q)
            HK_REG_CTRL: ctrl_q <= rx_i.data[HK_CTRL_W-1:0];
            HK_REG_TRIM: trim_q <= rx_i.data[HK_TRIM_W-1:0];
            // id registers are read only
            default: ;
          endcase
        end
      end
    end
  end

  always_comb begin
    case (addr_q)
      HK_REG_PROD: rd_data = HK_PROD_ID;
      HK_REG_MFGR: rd_data = HK_MFGR_ID;
      HK_REG_MASK: rd_data = HK_MASK_REV;
      HK_REG_CTRL: rd_data = {{(8-HK_CTRL_W){1'b0}}, ctrl_q};
      HK_REG_TRIM: rd_data = {{(8-HK_TRIM_W){1'b0}}, trim_q};
      default:     rd_data = 8'h00;
    endcase
  end

  // sdo stays low unless a read is in progress
  assign tx_byte_o = rd_mode_q ? rd_data : 8'h00;

  assign ctrl_o.xtal_ena = ctrl_q[HK_BIT_XTAL];
  assign ctrl_o.pll_bypass = ctrl_q[HK_BIT_BYPASS];
  assign ctrl_o.irq = ctrl_q[HK_BIT_IRQ];
  assign ctrl_o.soft_rst = ctrl_q[HK_BIT_SOFT_RST];
  assign ctrl_o.pll_trim = trim_q;

endmodule

/* source/hk_spi_shift.sv */
`timescale 1ns/1ps

module hk_spi_shift (
  input  logic              clk_i,
  input  logic              rst_i,
  input  soc_pkg::hk_pins_t pins_i,
  input  logic [7:0]        tx_byte_i,
  output soc_pkg::hk_rx_t   rx_o,
  output logic              sdo_o,
  output logic              sdo_oe_o
);

  import soc_pkg::*;

  logic       sck_q;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt_q;
  logic [6:0] rx_shift_q;
  logic       first_q;
  logic [7:0] tx_shift_q;
  hk_rx_t     rx_q;

  // edges only count inside a frame
  assign sck_rise = ~pins_i.csb & pins_i.sck & ~sck_q;
  assign sck_fall = ~pins_i.csb & ~pins_i.sck & sck_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sck_q <= 1'b0;
      bit_cnt_q <= '0;
      first_q <= 1'b1;
      tx_shift_q <= '0;
      rx_q <= '0;
    end else begin
      sck_q <= pins_i.sck;
      rx_q.valid <= 1'b0;
      if (pins_i.csb) begin
        // frame end drops any partial byte
        bit_cnt_q <= '0;
        first_q <= 1'b1;
        tx_shift_q <= '0;
      end else if (sck_rise) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
        if (bit_cnt_q == 3'd7) begin
          rx_q.valid <= 1'b1;
          rx_q.first <= first_q;
          rx_q.data <= {rx_shift_q, pins_i.sdi};
          first_q <= 1'b0;
        end
      end else if (sck_fall) begin
        // first falling edge of a byte loads the next reply
        if (bit_cnt_q == 3'd0) begin
          tx_shift_q <= tx_byte_i;
        end else begin
          tx_shift_q <= {tx_shift_q[6:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sck_rise) begin
      rx_shift_q <= {rx_shift_q[5:0], pins_i.sdi};
    end
  end

  assign rx_o = rx_q;
  assign sdo_o = tx_shift_q[7];
  assign sdo_oe_o = ~pins_i.csb;

  // a finished byte is reported while its frame is still open
  rx_only_in_frame: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(rx_o.valid) |-> !pins_i.csb
  );

endmodule

/* source/input_sync.sv */
`timescale 1ns/1ps

module input_sync #(
  parameter type T = logic,
  parameter T RST_VAL = '0,
  parameter int STAGES = soc_pkg::SYNC_STAGES
) (
  input  logic clk_i,
  input  logic rst_i,
  input  T     d_i,
  output T     q_o
);

  T sync_q [STAGES];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < STAGES; i++) begin
        sync_q[i] <= RST_VAL;
      end
    end else begin
      sync_q[0] <= d_i;
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign q_o = sync_q[STAGES-1];

endmodule

/* source/soc_chip_top.sv */
`timescale 1ns/1ps

module soc_chip_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  soc_pkg::wb_req_t           wb_req_i,
  output soc_pkg::wb_rsp_t           wb_rsp_o,
  input  logic                       hk_csb_i,
  input  logic                       hk_sck_i,
  input  logic                       hk_sdi_i,
  output logic                       hk_sdo_o,
  output logic                       hk_sdo_oe_o,
  output soc_pkg::hk_ctrl_t          hk_ctrl_o,
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
  output logic [soc_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_outenb_o
);

  import soc_pkg::*;

  // idle bus, chip deselected
  localparam hk_pins_t PINS_IDLE = '{csb: 1'b1, sck: 1'b0, sdi: 1'b0};

  hk_pins_t   pins_raw;
  hk_pins_t   pins_sync;
  gpio_t      gpio_in_sync;
  hk_rx_t     hk_rx;
  logic [7:0] hk_tx_byte;
  logic       bus_rst;
  wb_req_t    ram_req;
  wb_rsp_t    ram_rsp;
  wb_req_t    gpio_req;
  wb_rsp_t    gpio_rsp;

  assign pins_raw = '{csb: hk_csb_i, sck: hk_sck_i, sdi: hk_sdi_i};

  // housekeeping can hold the bus side in reset
  assign bus_rst = rst_i | hk_ctrl_o.soft_rst;

  input_sync #(
    .T      (hk_pins_t),
    .RST_VAL(PINS_IDLE)
  ) u_hk_sync (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .d_i  (pins_raw),
    .q_o  (pins_sync)
  );

  input_sync #(
    .T(gpio_t)
  ) u_gpio_sync (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .d_i  (gpio_in_i),
    .q_o  (gpio_in_sync)
  );

  hk_spi_shift u_hk_spi_shift (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .pins_i   (pins_sync),
    .tx_byte_i(hk_tx_byte),
    .rx_o     (hk_rx),
    .sdo_o    (hk_sdo_o),
    .sdo_oe_o (hk_sdo_oe_o)
  );

  hk_regfile u_hk_regfile (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .rx_i     (hk_rx),
    .tx_byte_o(hk_tx_byte),
    .ctrl_o   (hk_ctrl_o)
  );

  wb_addr_decode u_wb_addr_decode (
    .clk_i     (clk_i),
    .rst_i     (bus_rst),
    .req_i     (wb_req_i),
    .rsp_o     (wb_rsp_o),
    .ram_req_o (ram_req),
    .ram_rsp_i (ram_rsp),
    .gpio_req_o(gpio_req),
    .gpio_rsp_i(gpio_rsp)
  );

  wb_spram u_wb_spram (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .req_i(ram_req),
    .rsp_o(ram_rsp)
  );

  wb_gpio u_wb_gpio (
    .clk_i        (clk_i),
    .rst_i        (bus_rst),
    .req_i        (gpio_req),
    .rsp_o        (gpio_rsp),
    .gpio_in_i    (gpio_in_sync),
    .gpio_out_o   (gpio_out_o),
    .gpio_outenb_o(gpio_outenb_o)
  );

endmodule

/* source/soc_pkg.sv */
package soc_pkg;

  // bus geometry
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int SEL_W = 4;
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW = $clog2(RAM_WORDS);
  localparam int GPIO_W = 16;
  localparam int SYNC_STAGES = 2;

  // address map, top nibble selects the target
  localparam int REGION_W = 4;
  localparam logic [REGION_W-1:0] RAM_REGION = 4'h0;
  localparam logic [REGION_W-1:0] GPIO_REGION = 4'h2;
  localparam logic [3:0] GPIO_OUT_OFS = 4'h0;
  localparam logic [3:0] GPIO_OENB_OFS = 4'h4;
  localparam logic [3:0] GPIO_IN_OFS = 4'h8;

  // housekeeping spi
  localparam logic [7:0] HK_CMD_WRITE = 8'h80;
  localparam logic [7:0] HK_CMD_READ = 8'h40;
  localparam logic [7:0] HK_REG_PROD = 8'd0;
  localparam logic [7:0] HK_REG_MFGR = 8'd1;
  localparam logic [7:0] HK_REG_MASK = 8'd2;
  localparam logic [7:0] HK_REG_CTRL = 8'd3;
  localparam logic [7:0] HK_REG_TRIM = 8'd4;
  localparam logic [7:0] HK_PROD_ID = 8'h52;
  localparam logic [7:0] HK_MFGR_ID = 8'h56;
  localparam logic [7:0] HK_MASK_REV = 8'h01;
  localparam logic [7:0] HK_CTRL_RESET = 8'h03;
  localparam int HK_CTRL_W = 4;
  localparam int HK_TRIM_W = 4;
  // control register bit positions
  localparam int HK_BIT_XTAL = 0;
  localparam int HK_BIT_BYPASS = 1;
  localparam int HK_BIT_IRQ = 2;
  localparam int HK_BIT_SOFT_RST = 3;

  typedef logic [GPIO_W-1:0] gpio_t;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [SEL_W-1:0]  sel;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic csb;
    logic sck;
    logic sdi;
  } hk_pins_t;

  typedef struct packed {
    logic       valid;
    logic       first;
    logic [7:0] data;
  } hk_rx_t;

  typedef struct packed {
    logic                 xtal_ena;
    logic                 pll_bypass;
    logic                 irq;
    logic                 soft_rst;
    logic [HK_TRIM_W-1:0] pll_trim;
  } hk_ctrl_t;

endpackage

/* source/wb_addr_decode.sv */
`timescale 1ns/1ps

module wb_addr_decode (
  input  logic             clk_i,
  input  logic             rst_i,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o,
  output soc_pkg::wb_req_t ram_req_o,
  input  soc_pkg::wb_rsp_t ram_rsp_i,
  output soc_pkg::wb_req_t gpio_req_o,
  input  soc_pkg::wb_rsp_t gpio_rsp_i
);

  import soc_pkg::*;

  logic [REGION_W-1:0] region;
  logic                ram_hit;
  logic                gpio_hit;
  logic                none_hit;
  logic                none_ack_q;

  assign region = req_i.adr[ADDR_W-1 -: REGION_W];
  assign ram_hit = (region == RAM_REGION);
  assign gpio_hit = (region == GPIO_REGION);
  assign none_hit = ~ram_hit & ~gpio_hit;

  always_comb begin
    ram_req_o = req_i;
    ram_req_o.stb = req_i.stb & ram_hit;
    gpio_req_o = req_i;
    gpio_req_o.stb = req_i.stb & gpio_hit;
  end

  // unmapped space answers itself with the slave latency
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= req_i.cyc & req_i.stb & none_hit & ~none_ack_q;
    end
  end

  always_comb begin
    rsp_o.ack = ram_rsp_i.ack | gpio_rsp_i.ack | none_ack_q;
    if (ram_hit) begin
      rsp_o.dat = ram_rsp_i.dat;
    end else if (gpio_hit) begin
      rsp_o.dat = gpio_rsp_i.dat;
    end else begin
      rsp_o.dat = '0;
    end
  end

  // only one target is strobed or answering at a time
  one_target_stb: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $onehot0({ram_req_o.stb | ram_rsp_i.ack, gpio_req_o.stb | gpio_rsp_i.ack,
              (req_i.stb & none_hit) | none_ack_q})
  );

endmodule

/* source/wb_gpio.sv */
`timescale 1ns/1ps

module wb_gpio (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  soc_pkg::wb_req_t         req_i,
  output soc_pkg::wb_rsp_t         rsp_o,
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
  output logic [soc_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_outenb_o
);

  import soc_pkg::*;

  logic              req_hit;
  logic [3:0]        ofs;
  logic              ack_q;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] outenb_q;
  logic [GPIO_W-1:0] in_q;
  logic [DATA_W-1:0] rd_q;

  function automatic logic [GPIO_W-1:0] merge_bytes(
    input logic [GPIO_W-1:0] cur,
    input logic [DATA_W-1:0] wdat,
    input logic [SEL_W-1:0]  sel
  );
    logic [GPIO_W-1:0] res;
    res = cur;
    for (int b = 0; b < GPIO_W / 8; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = wdat[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign req_hit = req_i.cyc & req_i.stb & ~ack_q;
  assign ofs = req_i.adr[3:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      out_q <= '0;
      // pins come up as inputs
      outenb_q <= '1;
    end else begin
      ack_q <= req_hit;
      if (req_hit && req_i.we) begin
        case (ofs)
          GPIO_OUT_OFS:  out_q <= merge_bytes(out_q, req_i.dat, req_i.sel);
          GPIO_OENB_OFS: outenb_q <= merge_bytes(outenb_q, req_i.dat, req_i.sel);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    in_q <= gpio_in_i;
    if (req_hit) begin
      case (ofs)
        GPIO_OUT_OFS:  rd_q <= {{(DATA_W-GPIO_W){1'b0}}, out_q};
        GPIO_OENB_OFS: rd_q <= {{(DATA_W-GPIO_W){1'b0}}, outenb_q};
        GPIO_IN_OFS:   rd_q <= {{(DATA_W-GPIO_W){1'b0}}, in_q};
        default:       rd_q <= '0;
      endcase
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = rd_q;
  assign gpio_out_o = out_q;
  assign gpio_outenb_o = outenb_q;

endmodule

/* source/wb_spram.sv */
`timescale 1ns/1ps

module wb_spram (
  input  logic             clk_i,
  input  logic             rst_i,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o
);

  import soc_pkg::*;

  logic [DATA_W-1:0] mem_q [RAM_WORDS];
  logic [DATA_W-1:0] rd_q;
  logic [RAM_AW-1:0] word_idx;
  logic              req_hit;
  logic              ack_q;

  assign word_idx = req_i.adr[RAM_AW+1:2];
  assign req_hit = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hit) begin
      if (req_i.we) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (req_i.sel[b]) begin
            mem_q[word_idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
          end
        end
      end
      rd_q <= mem_q[word_idx];
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = rd_q;

  // master holds cyc until it sees the ack
  ack_in_cycle: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ack_q |-> req_i.cyc
  );

endmodule

/* src.f */
+incdir+test
source/soc_pkg.sv
source/input_sync.sv
source/hk_spi_shift.sv
source/hk_regfile.sv
source/wb_addr_decode.sv
source/wb_spram.sv
source/wb_gpio.sv
source/soc_chip_top.sv
test/tb_soc_chip_top.sv

/* test/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// drive point sits just after the rising edge
task automatic next_cycle();
  @(posedge clk);
  #2;
endtask

task automatic start_test(input string name);
  cur_test = name;
  test_err_base = errors + prop_fails;
endtask

task automatic end_test();
  int n;
  n = errors + prop_fails - test_err_base;
  tests++;
  if (n == 0) begin
    $display("test %s passed", cur_test);
  end else begin
    $display("test %s failed with %0d errors", cur_test, n);
  end
endtask

task automatic compare_value(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
  checks++;
  value_matches: assert (act === exp) else begin
    errors++;
    $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
  end
endtask

// one classic cycle, request held through the edge that samples ack
task automatic bus_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                          input logic [31:0] wdat, output logic [31:0] rdat);
  int   waited;
  logic got_ack;
  waited = 0;
  got_ack = 1'b0;
  rdat = '0;
  wb_req.cyc = 1'b1;
  wb_req.stb = 1'b1;
  wb_req.we = we;
  wb_req.adr = adr;
  wb_req.sel = sel;
  wb_req.dat = wdat;
  while (!got_ack && waited < ACK_TIMEOUT) begin
    @(negedge clk);
    waited++;
    if (wb_rsp.ack) begin
      got_ack = 1'b1;
      rdat = wb_rsp.dat;
    end
  end
  if (!got_ack) begin
    errors++;
    $display("timeout waiting for the bus ack at address %h", adr);
  end
  next_cycle();
  wb_req.cyc = 1'b0;
  wb_req.stb = 1'b0;
  wb_req.we = 1'b0;
  // idle cycle so every strobe starts from low
  next_cycle();
endtask

task automatic write_word(input logic [31:0] adr, input logic [3:0] sel,
                          input logic [31:0] wdat);
  logic [31:0] unused_rd;
  bus_access(1'b1, adr, sel, wdat, unused_rd);
endtask

task automatic read_word(input logic [31:0] adr, output logic [31:0] rdat);
  bus_access(1'b0, adr, 4'hF, 32'h0, rdat);
endtask

task automatic open_frame();
  hk_csb = 1'b0;
  repeat (SPI_HALF) next_cycle();
  compare_value("sdo enable in frame", 32'h1, 32'(hk_sdo_oe));
endtask

task automatic close_frame();
  repeat (SPI_HALF) next_cycle();
  hk_csb = 1'b1;
  repeat (8) next_cycle();
  compare_value("sdo enable idle", 32'h0, 32'(hk_sdo_oe));
endtask

// mode 0, msb first, sdo read just before each rising sck
task automatic shift_spi_byte(input logic [7:0] tx, output logic [7:0] rx);
  logic [7:0] got;
  got = '0;
  for (int i = 7; i >= 0; i--) begin
    hk_sdi = tx[i];
    repeat (SPI_HALF) next_cycle();
    got[i] = hk_sdo;
    hk_sck = 1'b1;
    repeat (SPI_HALF) next_cycle();
    hk_sck = 1'b0;
  end
  rx = got;
endtask

`endif

/* test/tb_soc_chip_top.sv */
`timescale 1ns/1ps

module tb_soc_chip_top;

  import soc_pkg::*;

  localparam int ACK_TIMEOUT = 16;
  localparam int SPI_HALF = 4;
  localparam int RAM_CHECKS = 8;
  localparam logic [31:0] GPIO_OUT_ADR = {GPIO_REGION, 24'h0, GPIO_OUT_OFS};
  localparam logic [31:0] GPIO_OENB_ADR = {GPIO_REGION, 24'h0, GPIO_OENB_OFS};
  localparam logic [31:0] GPIO_IN_ADR = {GPIO_REGION, 24'h0, GPIO_IN_OFS};
  localparam logic [31:0] NONE_ADR = 32'h5000_0010;

  logic        clk;
  logic        rst;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        hk_csb;
  logic        hk_sck;
  logic        hk_sdi;
  logic        hk_sdo;
  logic        hk_sdo_oe;
  hk_ctrl_t    hk_ctrl;
  gpio_t       gpio_in;
  gpio_t       gpio_out;
  gpio_t       gpio_outenb;
  int          errors;
  int          prop_fails = 0;
  int          checks;
  int          tests;
  int          test_err_base;
  string       cur_test;
  logic [31:0] ram_addr [RAM_CHECKS];
  logic [31:0] ram_exp [RAM_CHECKS];

  soc_chip_top DUT (
    .clk_i        (clk),
    .rst_i        (rst),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .hk_csb_i     (hk_csb),
    .hk_sck_i     (hk_sck),
    .hk_sdi_i     (hk_sdi),
    .hk_sdo_o     (hk_sdo),
    .hk_sdo_oe_o  (hk_sdo_oe),
    .hk_ctrl_o    (hk_ctrl),
    .gpio_in_i    (gpio_in),
    .gpio_out_o   (gpio_out),
    .gpio_outenb_o(gpio_outenb)
  );

  `include "tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ack_after_strobe: assert property (
    @(posedge clk) disable iff (rst)
    $rose(wb_req.stb) |=> wb_rsp.ack
  ) else begin
    prop_fails++;
    $display("bus ack did not follow the strobe by one cycle at %0t", $time);
  end

  ack_one_cycle: assert property (
    @(posedge clk) disable iff (rst)
    wb_rsp.ack |=> !wb_rsp.ack
  ) else begin
    prop_fails++;
    $display("bus ack stayed high for more than one cycle at %0t", $time);
  end

  // csb needs the synchronizer depth plus one edge to reach the enable
  sdo_oe_idle: assert property (
    @(posedge clk) disable iff (rst)
    hk_csb && $past(hk_csb) && $past(hk_csb, 2) |-> !hk_sdo_oe
  ) else begin
    prop_fails++;
    $display("sdo output enable is high while the chip is deselected at %0t", $time);
  end

  gpio_held_in_reset: assert property (
    @(posedge clk) disable iff (rst)
    hk_ctrl.soft_rst |=> (gpio_out == '0 && gpio_outenb == '1)
  ) else begin
    prop_fails++;
    $display("gpio left its reset values during soft reset at %0t", $time);
  end

  // byte lanes with sel set take the newer word
  function automatic logic [31:0] merge_by_sel(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic compare_ctrl(input logic [7:0] exp);
    compare_value("xtal_ena", 32'(exp[HK_BIT_XTAL]), 32'(hk_ctrl.xtal_ena));
    compare_value("pll_bypass", 32'(exp[HK_BIT_BYPASS]), 32'(hk_ctrl.pll_bypass));
    compare_value("irq", 32'(exp[HK_BIT_IRQ]), 32'(hk_ctrl.irq));
    compare_value("soft_rst", 32'(exp[HK_BIT_SOFT_RST]), 32'(hk_ctrl.soft_rst));
  endtask

  task automatic set_hk_ctrl(input logic [7:0] value);
    logic [7:0] rx_b;
    open_frame();
    shift_spi_byte(HK_CMD_WRITE, rx_b);
    shift_spi_byte(HK_REG_CTRL, rx_b);
    shift_spi_byte(value, rx_b);
    close_frame();
  endtask

  task automatic check_reset_values();
    start_test("reset");
    compare_value("ack", 32'h0, 32'(wb_rsp.ack));
    compare_value("sdo enable", 32'h0, 32'(hk_sdo_oe));
    compare_value("gpio outenb", 32'h0000_FFFF, 32'(gpio_outenb));
    compare_value("gpio out", 32'h0, 32'(gpio_out));
    compare_ctrl(HK_CTRL_RESET);
    end_test();
  endtask

  task automatic ram_byte_merge();
    logic [31:0] w1;
    logic [31:0] w2;
    logic [3:0]  sel;
    logic [31:0] rd;
    start_test("ram");
    for (int i = 0; i < RAM_CHECKS; i++) begin
      ram_addr[i] = {RAM_REGION, 28'(32'h40 + i * 20)};
      w1 = $urandom();
      w2 = $urandom();
      sel = 4'($urandom_range(14, 1));
      write_word(ram_addr[i], 4'hF, w1);
      write_word(ram_addr[i], sel, w2);
      ram_exp[i] = merge_by_sel(w1, w2, sel);
    end
    for (int i = 0; i < RAM_CHECKS; i++) begin
      read_word(ram_addr[i], rd);
      compare_value("ram word", ram_exp[i], rd);
    end
    end_test();
  endtask

  task automatic gpio_registers();
    gpio_t       gout;
    gpio_t       goenb;
    gpio_t       gin;
    logic [31:0] rd;
    start_test("gpio");
    gout = gpio_t'($urandom());
    goenb = gpio_t'($urandom());
    write_word(GPIO_OUT_ADR, 4'hF, {gpio_t'($urandom()), gout});
    write_word(GPIO_OENB_ADR, 4'hF, {gpio_t'($urandom()), goenb});
    read_word(GPIO_OUT_ADR, rd);
    compare_value("out reg", 32'(gout), rd);
    read_word(GPIO_OENB_ADR, rd);
    compare_value("outenb reg", 32'(goenb), rd);
    compare_value("out pins", 32'(gout), 32'(gpio_out));
    compare_value("outenb pins", 32'(goenb), 32'(gpio_outenb));
    gin = gpio_t'($urandom());
    gpio_in = gin;
    repeat (SYNC_STAGES + 2) next_cycle();
    read_word(GPIO_IN_ADR, rd);
    compare_value("in reg", 32'(gin), rd);
    end_test();
  endtask

  task automatic unmapped_access();
    logic [31:0] rd;
    start_test("unmapped");
    write_word(NONE_ADR, 4'hF, $urandom());
    read_word(NONE_ADR, rd);
    compare_value("read data", 32'h0, rd);
    end_test();
  endtask

  task automatic hk_id_read();
    logic [7:0] rx_b;
    start_test("hk_read");
    open_frame();
    shift_spi_byte(HK_CMD_READ, rx_b);
    shift_spi_byte(HK_REG_PROD, rx_b);
    shift_spi_byte(8'h00, rx_b);
    compare_value("product id", 32'(HK_PROD_ID), 32'(rx_b));
    shift_spi_byte(8'h00, rx_b);
    compare_value("manufacturer id", 32'(HK_MFGR_ID), 32'(rx_b));
    shift_spi_byte(8'h00, rx_b);
    compare_value("mask revision", 32'(HK_MASK_REV), 32'(rx_b));
    close_frame();
    end_test();
  endtask

  task automatic hk_ctrl_write();
    logic [7:0] ctrl_wr;
    logic [7:0] trim_wr;
    logic [7:0] rx_b;
    start_test("hk_write");
    // soft reset bit stays clear here
    ctrl_wr = {5'b0, 3'($urandom())};
    trim_wr = {4'b0, 4'($urandom())};
    open_frame();
    shift_spi_byte(HK_CMD_WRITE, rx_b);
    shift_spi_byte(HK_REG_CTRL, rx_b);
    shift_spi_byte(ctrl_wr, rx_b);
    shift_spi_byte(trim_wr, rx_b);
    close_frame();
    compare_ctrl(ctrl_wr);
    compare_value("pll_trim", 32'(trim_wr[HK_TRIM_W-1:0]), 32'(hk_ctrl.pll_trim));
    open_frame();
    shift_spi_byte(HK_CMD_READ, rx_b);
    shift_spi_byte(HK_REG_CTRL, rx_b);
    shift_spi_byte(8'h00, rx_b);
    compare_value("ctrl readback", 32'(ctrl_wr), 32'(rx_b));
    shift_spi_byte(8'h00, rx_b);
    compare_value("trim readback", 32'(trim_wr), 32'(rx_b));
    close_frame();
    end_test();
  endtask

  task automatic soft_reset_hold();
    gpio_t       gval;
    logic [31:0] rd;
    start_test("soft_reset");
    write_word(GPIO_OUT_ADR, 4'hF, 32'h0000_5AA5);
    write_word(GPIO_OENB_ADR, 4'hF, 32'h0000_00F0);
    set_hk_ctrl(HK_CTRL_RESET | 8'(1 << HK_BIT_SOFT_RST));
    compare_value("out in reset", 32'h0, 32'(gpio_out));
    compare_value("outenb in reset", 32'h0000_FFFF, 32'(gpio_outenb));
    set_hk_ctrl(HK_CTRL_RESET);
    gval = gpio_t'($urandom());
    write_word(GPIO_OUT_ADR, 4'hF, 32'(gval));
    compare_value("out after release", 32'(gval), 32'(gpio_out));
    for (int i = 0; i < RAM_CHECKS; i++) begin
      read_word(ram_addr[i], rd);
      compare_value("ram kept", ram_exp[i], rd);
    end
    end_test();
  endtask

  initial begin
    int unsigned seed;
    seed = $urandom(85);
    errors = 0;
    checks = 0;
    tests = 0;
    rst = 1'b1;
    wb_req = '0;
    hk_csb = 1'b1;
    hk_sck = 1'b0;
    hk_sdi = 1'b0;
    gpio_in = '0;
    repeat (2) next_cycle();
    rst = 1'b0;
    next_cycle();
    check_reset_values();
    ram_byte_merge();
    gpio_registers();
    unmapped_access();
    hk_id_read();
    hk_ctrl_write();
    soft_reset_hold();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks,
             errors + prop_fails);
    if (errors + prop_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
